// File: Makefile
VERILATOR  ?= verilator
TOP        := fpu_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert --top-module $(TOP)
LINT_FLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails on the fail message, a missing pass message or a nonzero exit
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Result: FAILED" $(LOG); then exit 1; fi; \
	if ! grep -q "Result: PASSED" $(LOG); then exit 1; fi; \
	if [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: all.f
+incdir+hw
hw/fpu_pkg.sv
hw/delay_line.sv
hw/fp_mul.sv
hw/fp_add.sv
hw/fpu_ctrl.sv
hw/fpu_top.sv
tests/fpu_assert.sv
tests/fpu_checker.sv
tests/fpu_tb.sv

// File: hw/delay_line.sv
// Fixed-latency register chain without reset; STAGES of 0 is a plain wire
`timescale 1ns/10ps

module delay_line #(
    parameter int WIDTH  = 32,
    parameter int STAGES = 1
) (
    input  logic             clk,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out
);

    generate
        if (STAGES == 0) begin : g_wire
            // No storage at all, output follows input in the same cycle
            assign data_out = data_in;
        end else if (STAGES == 1) begin : g_single
            always_ff @(posedge clk) begin
                data_out <= data_in;
            end
        end else begin : g_chain
            logic [WIDTH-1:0] taps [STAGES];

            // Tap 0 takes the input, each later tap takes its neighbour
            always_ff @(posedge clk) begin
                taps[0] <= data_in;
                for (int i = 1; i < STAGES; i++) begin
                    taps[i] <= taps[i-1];
                end
            end

            // Last tap is the delayed word
            assign data_out = taps[STAGES-1];
        end
    endgenerate

endmodule

// File: hw/fp_add.sv
// FP32 add with truncation and at most one left shift; exact cancellation gives +0, no NaN or infinity
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fp_add #(
    parameter int STAGES = `FP_ADD_STAGES
) (
    input  logic          clk,
    input  fpu_pkg::fp32_t a,
    input  fpu_pkg::fp32_t b,
    output fpu_pkg::fp32_t sum
);

    // Operand fields
    logic             sign_a;
    logic             sign_b;
    fpu_pkg::fp_exp_t  exp_a;
    fpu_pkg::fp_exp_t  exp_b;
    fpu_pkg::fp_mant_t frac_a;
    fpu_pkg::fp_mant_t frac_b;
    logic [23:0]      sig_a;
    logic [23:0]      sig_b;
    logic             zero_a;
    logic             zero_b;

    // Alignment, hidden bit at 24 and one guard bit at 0
    fpu_pkg::fp_exp_t  exp_diff;
    fpu_pkg::fp_exp_t  big_exp;
    logic [24:0]      align_a;
    logic [24:0]      align_b;

    // Extra top bit holds the carry of a same-sign add
    logic [25:0]      mag_sum;
    logic             res_sign;
    fpu_pkg::fp_exp_t  res_exp;
    fpu_pkg::fp_mant_t res_frac;
    fpu_pkg::fp32_t    sum_next;

    assign {sign_a, exp_a, frac_a} = a;
    assign {sign_b, exp_b, frac_b} = b;

    assign sig_a = {(exp_a != 8'd0), frac_a};
    assign sig_b = {(exp_b != 8'd0), frac_b};

    assign zero_a = (exp_a == 8'd0) && (frac_a == 23'd0);
    assign zero_b = (exp_b == 8'd0) && (frac_b == 23'd0);

    always_comb begin
        exp_diff = '0;
        big_exp  = '0;
        align_a  = '0;
        align_b  = '0;
        mag_sum  = '0;
        res_sign = 1'b0;
        res_exp  = '0;
        res_frac = '0;
        sum_next = '0;

        if (zero_a) begin
            // Zero operand passes the other one bit for bit
            sum_next = b;
        end else if (zero_b) begin
            sum_next = a;
        end else begin
            // Smaller exponent gets shifted right onto the larger one
            if (exp_a >= exp_b) begin
                big_exp  = exp_a;
                exp_diff = exp_a - exp_b;
                align_a  = {sig_a, 1'b0};
                align_b  = {sig_b, 1'b0} >> exp_diff;
            end else begin
                big_exp  = exp_b;
                exp_diff = exp_b - exp_a;
                align_a  = {sig_a, 1'b0} >> exp_diff;
                align_b  = {sig_b, 1'b0};
            end

            // Sign-magnitude add or subtract, larger magnitude sets the sign
            if (sign_a == sign_b) begin
                mag_sum  = align_a + align_b;
                res_sign = sign_a;
            end else if (align_a >= align_b) begin
                mag_sum  = align_a - align_b;
                res_sign = sign_a;
            end else begin
                mag_sum  = align_b - align_a;
                res_sign = sign_b;
            end

            // Single-step normalization
            res_exp = big_exp;
            if (mag_sum[25]) begin
                // Carry out, shift right
                res_frac = mag_sum[24:2];
                res_exp  = big_exp + 8'd1;
            end else if (mag_sum[24]) begin
                res_frac = mag_sum[23:1];
            end else begin
                // One left shift, guard bit moves into the LSB
                res_frac = mag_sum[22:0];
                res_exp  = big_exp - 8'd1;
            end

            if (mag_sum == 26'd0) begin
                sum_next = '0;
            end else begin
                sum_next = {res_sign, res_exp, res_frac};
            end
        end
    end

    delay_line #(
        .WIDTH  ($bits(fpu_pkg::fp32_t)),
        .STAGES (STAGES)
    ) u_delay (
        .clk      (clk),
        .data_in  (sum_next),
        .data_out (sum)
    );

endmodule

// File: hw/fp_mul.sv
// FP32 multiply with truncation; no NaN, infinity or denormal inputs, exponent range errors saturate
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fp_mul #(
    parameter int STAGES = `FP_MUL_STAGES
) (
    input  logic          clk,
    input  fpu_pkg::fp32_t a,
    input  fpu_pkg::fp32_t b,
    output fpu_pkg::fp32_t product,
    output logic          range
);

    // Operand fields
    logic             sign_a;
    logic             sign_b;
    fpu_pkg::fp_exp_t  exp_a;
    fpu_pkg::fp_exp_t  exp_b;
    fpu_pkg::fp_mant_t frac_a;
    fpu_pkg::fp_mant_t frac_b;

    // Significands with the hidden bit restored
    logic [23:0] sig_a;
    logic [23:0] sig_b;
    logic        zero_a;
    logic        zero_b;

    // Core arithmetic
    logic [47:0]        sig_prod;
    logic signed [9:0]  exp_res;
    logic               res_sign;
    fpu_pkg::fp_mant_t  res_frac;

    // Product plus range flag, before and after the delay line
    fpu_pkg::fpu_result_t mul_next;
    fpu_pkg::fpu_result_t mul_q;

    assign {sign_a, exp_a, frac_a} = a;
    assign {sign_b, exp_b, frac_b} = b;

    // Hidden bit only for a nonzero exponent
    assign sig_a = {(exp_a != 8'd0), frac_a};
    assign sig_b = {(exp_b != 8'd0), frac_b};

    assign zero_a = (exp_a == 8'd0) && (frac_a == 23'd0);
    assign zero_b = (exp_b == 8'd0) && (frac_b == 23'd0);

    always_comb begin
        // 1.x times 1.x lands in [1, 4)
        sig_prod = sig_a * sig_b;
        res_sign = sign_a ^ sign_b;

        // Signed, wide enough for 255 + 255 - 127 + 1
        exp_res = $signed({2'b00, exp_a}) + $signed({2'b00, exp_b}) - 10'sd127;

        // One-bit normalization, low bits are simply dropped
        if (sig_prod[47]) begin
            res_frac = sig_prod[46:24];
            exp_res  = exp_res + 10'sd1;
        end else begin
            res_frac = sig_prod[45:23];
        end

        mul_next = '0;
        if (zero_a || zero_b) begin
            // Any zero operand gives +0 with no range error
            mul_next = '0;
        end else if (exp_res > 10'sd254) begin
            // Too large, signed infinity
            mul_next.value = {res_sign, 8'hff, 23'd0};
            mul_next.range = 1'b1;
        end else if (exp_res < 10'sd1) begin
            // Too small, signed zero
            mul_next.value = {res_sign, 31'd0};
            mul_next.range = 1'b1;
        end else begin
            mul_next.value = {res_sign, exp_res[7:0], res_frac};
            mul_next.range = 1'b0;
        end
    end

    // Value and flag share one delay so they stay aligned
    delay_line #(
        .WIDTH  ($bits(fpu_pkg::fpu_result_t)),
        .STAGES (STAGES)
    ) u_delay (
        .clk      (clk),
        .data_in  (mul_next),
        .data_out (mul_q)
    );

    assign product = mul_q.value;
    assign range   = mul_q.range;

endmodule

// File: hw/fpu_ctrl.sv
// Four-phase req/ack job sequencer, one job in flight; datapath latencies must match the parameters
`timescale 1ns/10ps

module fpu_ctrl #(
    parameter int MUL_STAGES = 2,
    parameter int ADD_STAGES = 2
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  fpu_pkg::fpu_job_t    job,
    output logic                 ack,
    output fpu_pkg::fpu_result_t result,
    output fpu_pkg::fp32_t       mul_a,
    output fpu_pkg::fp32_t       mul_b,
    input  fpu_pkg::fp32_t       mul_out,
    input  logic                 mul_range,
    output fpu_pkg::fp32_t       add_a,
    output fpu_pkg::fp32_t       add_b,
    input  fpu_pkg::fp32_t       add_out
);

    // Counter wide enough for the deeper of the two pipelines
    localparam int MAX_STAGES = (MUL_STAGES > ADD_STAGES) ? MUL_STAGES : ADD_STAGES;
    localparam int CNT_W      = (MAX_STAGES < 1) ? 1 : $clog2(MAX_STAGES + 1);

    // Load values for each phase
    // MAC add phase is one shorter since the adder already sees the live product
    localparam logic [CNT_W-1:0] MUL_LOAD = CNT_W'(MUL_STAGES);
    localparam logic [CNT_W-1:0] ADD_LOAD = CNT_W'(ADD_STAGES);
    localparam logic [CNT_W-1:0] MAC_LOAD = CNT_W'((ADD_STAGES > 0) ? ADD_STAGES - 1 : 0);

    fpu_pkg::fpu_state_e state;
    logic [CNT_W-1:0]    cnt;
    fpu_pkg::fpu_job_t   job_q;
    fpu_pkg::fp32_t      prod_q;
    logic                rng_q;
    logic                last;
    logic                is_mac;

    assign last   = (cnt == '0);
    assign is_mac = (job_q.op == fpu_pkg::OP_MAC);
    assign ack    = (state == fpu_pkg::ST_DONE);

    // Multiplier always works on the registered a and b
    assign mul_a = job_q.a;
    assign mul_b = job_q.b;

    // MAC feeds the live product during ST_MUL, then the held copy
    always_comb begin
        if (is_mac) begin
            add_a = (state == fpu_pkg::ST_ADD) ? prod_q : mul_out;
            add_b = job_q.c;
        end else begin
            add_a = job_q.a;
            add_b = job_q.b;
        end
    end

    // Job only taken on the accepting edge
    always_ff @(posedge clk) begin
        if (state == fpu_pkg::ST_IDLE && req) begin
            job_q <= job;
        end
        if (state == fpu_pkg::ST_MUL && last) begin
            prod_q <= mul_out;
            rng_q  <= mul_range;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= fpu_pkg::ST_IDLE;
            cnt    <= '0;
            result <= '0;
        end else begin
            case (state)
                fpu_pkg::ST_IDLE: begin
                    if (req) begin
                        // Unused opcode runs down the add path
                        if (job.op == fpu_pkg::OP_MUL || job.op == fpu_pkg::OP_MAC) begin
                            state <= fpu_pkg::ST_MUL;
                            cnt   <= MUL_LOAD;
                        end else begin
                            state <= fpu_pkg::ST_ADD;
                            cnt   <= ADD_LOAD;
                        end
                    end
                end
                fpu_pkg::ST_MUL: begin
                    if (!last) begin
                        cnt <= cnt - 1'b1;
                    end else if (!is_mac) begin
                        state        <= fpu_pkg::ST_DONE;
                        result.value <= mul_out;
                        result.range <= mul_range;
                    end else if (ADD_STAGES == 0) begin
                        // Combinational adder already holds the final sum
                        state        <= fpu_pkg::ST_DONE;
                        result.value <= add_out;
                        result.range <= mul_range;
                    end else begin
                        state <= fpu_pkg::ST_ADD;
                        cnt   <= MAC_LOAD;
                    end
                end
                fpu_pkg::ST_ADD: begin
                    if (!last) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        state        <= fpu_pkg::ST_DONE;
                        result.value <= add_out;
                        result.range <= is_mac ? rng_q : 1'b0;
                    end
                end
                fpu_pkg::ST_DONE: begin
                    // Hold result and ack until the requester lets go
                    if (!req) begin
                        state <= fpu_pkg::ST_IDLE;
                    end
                end
                default: begin
                    state <= fpu_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/fpu_defs.svh
// Word width and default pipeline depths; stage counts of 0 make a block purely combinational
`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// IEEE single precision only
`define FP_WIDTH 32

// Register stages behind the multiplier core
// Zero gives a combinational path from operands to product
`define FP_MUL_STAGES 2

// Register stages behind the adder core
// Zero gives a combinational path from operands to sum
`define FP_ADD_STAGES 2

// Ack latency seen by the requester, counted from the edge that samples req
// OP_MUL   FP_MUL_STAGES + 1
// OP_ADD   FP_ADD_STAGES + 1
// OP_MAC   FP_MUL_STAGES + FP_ADD_STAGES + 1

`endif

// File: hw/fpu_pkg.sv
// Shared FPU types; opcode 2'b11 is unused and the control FSM runs it as a plain add
`include "fpu_defs.svh"

package fpu_pkg;

    // One single-precision word, sign in the top bit
    typedef logic [`FP_WIDTH-1:0] fp32_t;

    // Biased exponent field, bias 127
    typedef logic [7:0] fp_exp_t;

    // Stored fraction without the hidden bit
    typedef logic [22:0] fp_mant_t;

    typedef enum logic [1:0] {
        OP_MUL = 2'd0,
        OP_ADD = 2'd1,
        OP_MAC = 2'd2
    } fpu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_MUL  = 2'd1,
        ST_ADD  = 2'd2,
        ST_DONE = 2'd3
    } fpu_state_e;

    // Job as handed over by the requester, c only used by OP_MAC
    typedef struct packed {
        fpu_op_e op;
        fp32_t   a;
        fp32_t   b;
        fp32_t   c;
    } fpu_job_t;

    // Range is set when the multiplier saturated to infinity or flushed to zero
    typedef struct packed {
        fp32_t value;
        logic  range;
    } fpu_result_t;

endpackage

// File: hw/fpu_top.sv
// FPU top level; pipeline depths come from the shared defines and must match on both sides
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  fpu_pkg::fpu_job_t    job,
    output logic                 ack,
    output fpu_pkg::fpu_result_t result
);

    // Datapath operands and results
    fpu_pkg::fp32_t mul_a;
    fpu_pkg::fp32_t mul_b;
    fpu_pkg::fp32_t mul_out;
    logic           mul_range;
    fpu_pkg::fp32_t add_a;
    fpu_pkg::fp32_t add_b;
    fpu_pkg::fp32_t add_out;

    // Sequencer counts the same stage numbers the datapath is built with
    fpu_ctrl #(
        .MUL_STAGES (`FP_MUL_STAGES),
        .ADD_STAGES (`FP_ADD_STAGES)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .job       (job),
        .ack       (ack),
        .result    (result),
        .mul_a     (mul_a),
        .mul_b     (mul_b),
        .mul_out   (mul_out),
        .mul_range (mul_range),
        .add_a     (add_a),
        .add_b     (add_b),
        .add_out   (add_out)
    );

    fp_mul #(.STAGES(`FP_MUL_STAGES)) u_mul (
        .clk     (clk),
        .a       (mul_a),
        .b       (mul_b),
        .product (mul_out),
        .range   (mul_range)
    );

    fp_add #(.STAGES(`FP_ADD_STAGES)) u_add (
        .clk (clk),
        .a   (add_a),
        .b   (add_b),
        .sum (add_out)
    );

endmodule

// File: tests/fpu_assert.sv
// Handshake and reset assertions for the FPU control FSM; relies on a synchronous active-high reset
`timescale 1ns/10ps

module fpu_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 req,
    input logic                 ack,
    input fpu_pkg::fpu_result_t result
);

    // Any reset cycle leaves ack low on the next edge
    property ack_low_after_reset;
        @(posedge clk) rst |=> !ack;
    endproperty

    // Ack only comes up while the requester still asks
    property ack_rises_with_req;
        @(posedge clk) disable iff (rst) $rose(ack) |-> req;
    endproperty

    // Result frozen for as long as ack stays high
    property result_held_with_ack;
        @(posedge clk) disable iff (rst) (ack && $past(ack)) |-> (result == $past(result));
    endproperty

    a_ack_low_after_reset: assert property (ack_low_after_reset)
        else $error("ack was high in the cycle after reset");

    a_ack_rises_with_req: assert property (ack_rises_with_req)
        else $error("ack rose while req was low");

    a_result_held_with_ack: assert property (result_held_with_ack)
        else $error("result changed while ack was high");

endmodule

// File: tests/fpu_checker.sv
// Result checker for one job in flight; expected ack latencies come from the shared stage defines
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req,
    input  logic                 ack,
    input  fpu_pkg::fpu_job_t    job,
    input  fpu_pkg::fpu_result_t result,
    input  logic [127:0]         name,
    input  fpu_pkg::fpu_result_t expected,
    output int                   pass_count,
    output int                   fail_count
);

    // Bookkeeping for the job in flight
    logic                 busy;
    logic                 ack_q;
    logic                 drop_q;
    int                   cyc;
    int                   start_cyc;
    int                   lat;
    int                   errs;
    fpu_pkg::fpu_op_e     op_q;
    logic [127:0]         name_q;
    fpu_pkg::fpu_result_t exp_q;
    fpu_pkg::fpu_result_t held;

    // Edges from the sampling edge to the edge that raises ack
    function automatic int expected_latency(input fpu_pkg::fpu_op_e op);
        case (op)
            fpu_pkg::OP_MUL: return `FP_MUL_STAGES + 1;
            fpu_pkg::OP_MAC: return `FP_MUL_STAGES + `FP_ADD_STAGES + 1;
            default:         return `FP_ADD_STAGES + 1;
        endcase
    endfunction

    // Values read here are the ones the DUT flops see on the same edge
    always @(posedge clk) begin
        if (rst) begin
            busy       = 1'b0;
            ack_q      = 1'b0;
            drop_q     = 1'b0;
            cyc        = 0;
            start_cyc  = 0;
            errs       = 0;
            pass_count = 0;
            fail_count = 0;
        end else begin
            cyc = cyc + 1;

            // Idle unit sees req on the edge that takes the job
            if (req && !ack && !busy) begin
                busy      = 1'b1;
                start_cyc = cyc;
                op_q      = job.op;
                name_q    = name;
                exp_q     = expected;
                errs      = 0;
            end

            // Ack went high on the previous edge so the result has settled
            if (ack && !ack_q) begin
                if (!busy) begin
                    $display("FAIL ack rose while no job was in flight");
                    errs = errs + 1;
                end
                busy = 1'b0;
                held = result;
                lat  = cyc - start_cyc - 1;
                if (result.value !== exp_q.value) begin
                    $display("FAIL %0s: value expected %h, actual %h",
                             name_q, exp_q.value, result.value);
                    errs = errs + 1;
                end
                if (result.range !== exp_q.range) begin
                    $display("FAIL %0s: range flag expected %b, actual %b",
                             name_q, exp_q.range, result.range);
                    errs = errs + 1;
                end
                if (lat != expected_latency(op_q)) begin
                    $display("FAIL %0s: ack latency expected %0d, actual %0d",
                             name_q, expected_latency(op_q), lat);
                    errs = errs + 1;
                end
            end

            // Result must not move while the requester holds on
            if (ack && ack_q && result !== held) begin
                $display("FAIL %0s: result changed under ack, expected %h, actual %h",
                         name_q, held, result);
                errs = errs + 1;
                held = result;
            end

            // Req seen low last edge means ack must already be down
            if (ack && drop_q) begin
                $display("FAIL %0s: ack still high one cycle after req dropped", name_q);
                errs = errs + 1;
            end

            // Ack fell and the job is over
            if (!ack && ack_q) begin
                // A legal fall follows an edge that saw req low
                if (!drop_q) begin
                    $display("FAIL %0s: ack dropped while req was still high", name_q);
                    errs = errs + 1;
                end
                if (errs == 0) begin
                    pass_count = pass_count + 1;
                    $display("PASS %0s: value %h, range %b, ack after %0d cycles",
                             name_q, held.value, held.range, lat);
                end else begin
                    fail_count = fail_count + 1;
                    $display("FAIL %0s: %0d check(s) failed", name_q, errs);
                end
            end

            drop_q = ack && !req;
            ack_q  = ack;
        end
    end

endmodule

// File: tests/fpu_tb.sv
// FPU testbench; operands are exact so truncation never alters an expected value
`timescale 1ns/10ps
`include "fpu_defs.svh"

module fpu_tb;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 12;
    localparam int MAX_GAP      = 4;
    localparam int MAX_HOLD     = 5;

    // Per job: drive, latency, hold, release and gap, plus margin
    localparam int TIMEOUT_CYCLES = RESET_CYCLES
        + NUM_TESTS * (`FP_MUL_STAGES + `FP_ADD_STAGES + 8 + MAX_HOLD + MAX_GAP);

    // One table row, hold is extra cycles req stays high after ack
    typedef struct packed {
        logic [127:0]         name;
        fpu_pkg::fpu_job_t    job;
        fpu_pkg::fpu_result_t expected;
        logic [3:0]           hold;
    } test_vec_t;

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 req;
    logic                 ack;
    fpu_pkg::fpu_job_t    job;
    fpu_pkg::fpu_result_t result;

    // Current row as seen by the checker
    logic [127:0]         cur_name;
    fpu_pkg::fpu_result_t cur_exp;
    int                   pass_count;
    int                   fail_count;

    test_vec_t            tests [NUM_TESTS];
    int                   n_tests;
    int                   seed;
    int                   gap;

    always #(CLK_PERIOD / 2) clk = ~clk;

    fpu_top DUT (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .job    (job),
        .ack    (ack),
        .result (result)
    );

    fpu_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .ack        (ack),
        .job        (job),
        .result     (result),
        .name       (cur_name),
        .expected   (cur_exp),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    bind fpu_ctrl fpu_assert u_assert (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .ack    (ack),
        .result (result)
    );

    // Appends one row to the table
    task automatic add_test(input logic [127:0] tname, input fpu_pkg::fpu_op_e op,
                            input fpu_pkg::fp32_t a, input fpu_pkg::fp32_t b,
                            input fpu_pkg::fp32_t c, input fpu_pkg::fp32_t value,
                            input logic range, input logic [3:0] hold);
        tests[n_tests].name           = tname;
        tests[n_tests].job.op         = op;
        tests[n_tests].job.a          = a;
        tests[n_tests].job.b          = b;
        tests[n_tests].job.c          = c;
        tests[n_tests].expected.value = value;
        tests[n_tests].expected.range = range;
        tests[n_tests].hold           = hold;
        n_tests = n_tests + 1;
    endtask

    initial begin
        rst      = 1'b1;
        req      = 1'b0;
        job      = '0;
        cur_name = '0;
        cur_exp  = '0;
        n_tests  = 0;
        gap      = 0;
        seed     = 32'hdb4ec13c;

        // 3 x -2.5 = -7.5 and 0.5 x 0.5 = 0.25
        add_test("mul_3_x_m2p5", fpu_pkg::OP_MUL, 32'h40400000, 32'hc0200000, '0,
                 32'hc0f00000, 1'b0, 4'd0);
        add_test("mul_half_half", fpu_pkg::OP_MUL, 32'h3f000000, 32'h3f000000, '0,
                 32'h3e800000, 1'b0, 4'd0);
        // 6 + 0.75 = 6.75, held long after ack
        add_test("add_6_0p75", fpu_pkg::OP_ADD, 32'h40c00000, 32'h3f400000, '0,
                 32'h40d80000, 1'b0, 4'd5);
        // 5 - 3 = 2 and -8 + 2 = -6, both need one left shift
        add_test("add_5_m3", fpu_pkg::OP_ADD, 32'h40a00000, 32'hc0400000, '0,
                 32'h40000000, 1'b0, 4'd0);
        add_test("add_m8_2", fpu_pkg::OP_ADD, 32'hc1000000, 32'h40000000, '0,
                 32'hc0c00000, 1'b0, 4'd1);
        // Zero passes the other operand unchanged
        add_test("add_zero_a", fpu_pkg::OP_ADD, 32'h00000000, 32'hbfb00000, '0,
                 32'hbfb00000, 1'b0, 4'd0);
        add_test("add_zero_b", fpu_pkg::OP_ADD, 32'h41280000, 32'h00000000, '0,
                 32'h41280000, 1'b0, 4'd0);
        // 0 x -7 gives +0, no range error
        add_test("mul_zero", fpu_pkg::OP_MUL, 32'h00000000, 32'hc0e00000, '0,
                 32'h00000000, 1'b0, 4'd0);
        // 2 x 3 + 1.5 = 7.5 and 4 x -0.25 + 10 = 9
        add_test("mac_2x3_1p5", fpu_pkg::OP_MAC, 32'h40000000, 32'h40400000, 32'h3fc00000,
                 32'h40f00000, 1'b0, 4'd0);
        add_test("mac_4xm0p25_10", fpu_pkg::OP_MAC, 32'h40800000, 32'hbe800000, 32'h41200000,
                 32'h41100000, 1'b0, 4'd3);
        // 2^100 x -2^100 overflows, -2^-100 x 2^-100 underflows
        add_test("mul_ovf_inf", fpu_pkg::OP_MUL, 32'h71800000, 32'hf1800000, '0,
                 32'hff800000, 1'b1, 4'd0);
        add_test("mul_unf_zero", fpu_pkg::OP_MUL, 32'h8d800000, 32'h0d800000, '0,
                 32'h80000000, 1'b1, 4'd2);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge clk);
            job      <= tests[i].job;
            cur_name <= tests[i].name;
            cur_exp  <= tests[i].expected;
            req      <= 1'b1;

            // Phase 2, unit raises ack
            @(posedge clk);
            while (!ack) @(posedge clk);
            repeat (tests[i].hold) @(posedge clk);

            // Phase 3 and 4, release and wait for ack to drop
            req <= 1'b0;
            @(posedge clk);
            while (ack) @(posedge clk);

            gap = $unsigned($random(seed)) % (MAX_GAP + 1);
            repeat (gap) @(posedge clk);
        end

        // Let the checker close the last job
        repeat (2) @(posedge clk);
        @(negedge clk);

        $display("Tests: %0d passed, %0d failed, %0d in table",
                 pass_count, fail_count, NUM_TESTS);
        if (fail_count == 0 && pass_count == NUM_TESTS) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: the DUT did not finish all jobs within %0d cycles", TIMEOUT_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

endmodule
